// ==== sources.f ====
+incdir+verilog
verilog/rv_isa_pkg.sv
verilog/core_pkg.sv
verilog/decoder.sv
verilog/alu.sv
verilog/register_file.sv
verilog/core.sv
verilog/memory.sv
verilog/cpu_top.sv
testbench/tb_clock.sv
testbench/cpu_tb.sv

// ==== testbench/cpu_tb.sv ====
`include "core_defines.svh"

module cpu_tb;

    logic                               clk;
    logic                               rst;
    logic                               load_en;
    logic [$clog2(`CORE_MEM_WORDS)-1:0] load_addr;
    logic [31:0]                        load_data;
    logic                               retire;
    core_pkg::retire_t                  retire_info;

    logic [31:0]       prog [$];
    core_pkg::retire_t expect_q [$];
    logic [31:0]       model [32];
    logic [31:0]       dmem_model [`CORE_MEM_WORDS];
    logic [15:0]       lfsr = 16'd27724;
    int                checks;
    int                check_errors;
    int                timeout_errors;

    tb_clock #(.period(100)) u_clock (.clk(clk));

    cpu_top DUT (
        .clk         (clk),
        .rst         (rst),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .retire      (retire),
        .retire_info (retire_info)
    );

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [11:0] rand_bits(input int n);
        logic [11:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v[i] = fb;
        end
        return v;
    endfunction

    function automatic logic [31:0] sext12(input logic [11:0] imm);
        return {{20{imm[11]}}, imm};
    endfunction

    // alt selects sub and sra
    function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'd0, $signed(a) < $signed(b)};
            3'b011:  return {31'd0, a < b};
            3'b100:  return a ^ b;
            3'b101: begin
                if (alt) begin
                    return $signed(a) >>> b[4:0];
                end else begin
                    return a >> b[4:0];
                end
            end
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        checks++;
        assert (got === want) else begin
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, want);
            check_errors++;
        end
    endtask

    task automatic push(input logic [31:0] word, input logic [4:0] rd,
                        input logic [31:0] value, input logic we);
        core_pkg::retire_t r;
        r.pc        = `CORE_RESET_PC + prog.size() * 4;
        r.rd        = rd;
        r.value     = value;
        r.reg_write = we;
        prog.push_back(word);
        expect_q.push_back(r);
        if (we && rd != 5'd0) begin
            model[rd] = value;
        end
    endtask

    task automatic r_type(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] rd,
                          input logic [4:0] rs1, input logic [4:0] rs2);
        push({f7, rs2, rs1, f3, rd, 7'h33}, rd,
             ref_result(f3, f7[5], model[rs1], model[rs2]), 1'b1);
    endtask

    // imm[10] picks srai only for funct3 101
    task automatic i_type(input logic [2:0] f3, input logic [4:0] rd, input logic [4:0] rs1,
                          input logic [11:0] imm);
        logic alt;
        alt = f3 == 3'b101 && imm[10];
        push({imm, rs1, f3, rd, 7'h13}, rd, ref_result(f3, alt, model[rs1], sext12(imm)), 1'b1);
    endtask

    task automatic load_word(input logic [4:0] rd, input logic [4:0] rs1, input logic [11:0] imm);
        logic [31:0] addr;
        addr = model[rs1] + sext12(imm);
        push({imm, rs1, 3'b010, rd, 7'h03}, rd, dmem_model[addr[9:2]], 1'b1);
    endtask

    task automatic store_word(input logic [4:0] rs2, input logic [4:0] rs1,
                              input logic [11:0] imm);
        logic [31:0] addr;
        addr = model[rs1] + sext12(imm);
        dmem_model[addr[9:2]] = model[rs2];
        push({imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'h23}, 5'd0, addr, 1'b0);
    endtask

    task automatic raw_word(input logic [31:0] word);
        push(word, 5'd0, 32'd0, 1'b0);
    endtask

    // unused words decode as illegal and carry their own address
    task automatic fill_memory();
        logic [7:0] a;
        for (int i = 0; i < `CORE_MEM_WORDS; i++) begin
            a = i;
            @(negedge clk);
            load_en   = 1'b1;
            load_addr = a;
            load_data = {a, ~a, a, 8'h7f};
            dmem_model[i] = load_data;
        end
        @(negedge clk);
        load_en = 1'b0;
    endtask

    task automatic reset_and_load();
        int cycles;
        cycles = prog.size() > 7 ? prog.size() : 7;
        @(negedge clk);
        rst = 1'b1;
        for (int c = 1; c <= cycles; c++) begin
            @(negedge clk);
            load_en = 1'b0;
            if (c <= prog.size()) begin
                load_en   = 1'b1;
                load_addr = c - 1;
                load_data = prog[c - 1];
            end
            assert (retire === 1'b0) else begin
                $display("retire pulsed while reset was held");
                check_errors++;
            end
        end
        @(negedge clk);
        assert (retire === 1'b0) else begin
            $display("retire pulsed while reset was held");
            check_errors++;
        end
        load_en = 1'b0;
        rst     = 1'b0;
    endtask

    task automatic run_program(input string name);
        int                gap;
        core_pkg::retire_t want;
        reset_and_load();
        for (int k = 0; k < expect_q.size(); k++) begin
            want = expect_q[k];
            gap  = 0;
            do begin
                @(negedge clk);
                gap++;
            end while (retire !== 1'b1 && gap < 20);
            if (retire !== 1'b1) begin
                $display("%s: no retire pulse for instruction %0d", name, k);
                timeout_errors++;
                break;
            end
            // writeback is the fifth cycle when release counts as the first
            check_value("retire gap", gap, k == 0 ? 4 : 5);
            check_value("retire_info.pc", retire_info.pc, want.pc);
            check_value("retire_info.reg_write", retire_info.reg_write, want.reg_write);
            if (want.reg_write) begin
                check_value("retire_info.rd", retire_info.rd, want.rd);
                check_value("retire_info.value", retire_info.value, want.value);
            end
        end
        prog.delete();
        expect_q.delete();
        foreach (model[i]) model[i] = '0;
    endtask

    task automatic reset_test();
        i_type(3'b000, 5'd1, 5'd0, 12'd5);
        i_type(3'b000, 5'd2, 5'd1, 12'd3);
        run_program("reset");
    endtask

    task automatic arith_test();
        for (int r = 1; r <= 4; r++) begin
            i_type(3'b000, 5'(r), 5'd0, rand_bits(12));
        end
        r_type(7'h00, 3'b000, 5'd5, 5'd1, 5'd2);
        r_type(7'h20, 3'b000, 5'd6, 5'd3, 5'd4);
        r_type(7'h00, 3'b111, 5'd7, 5'd1, 5'd3);
        r_type(7'h00, 3'b110, 5'd8, 5'd2, 5'd4);
        r_type(7'h00, 3'b100, 5'd9, 5'd5, 5'd6);
        i_type(3'b111, 5'd10, 5'd1, rand_bits(12));
        i_type(3'b110, 5'd11, 5'd2, rand_bits(12));
        i_type(3'b100, 5'd12, 5'd6, rand_bits(12));
        run_program("arith");
    endtask

    task automatic shift_compare_test();
        // x1 negative and wide, x2 positive, x3 a shift amount
        i_type(3'b000, 5'd1, 5'd0, rand_bits(11) | 12'h800);
        i_type(3'b001, 5'd1, 5'd1, 12'd9);
        i_type(3'b000, 5'd2, 5'd0, rand_bits(11));
        i_type(3'b000, 5'd3, 5'd0, rand_bits(5));
        r_type(7'h00, 3'b001, 5'd4, 5'd1, 5'd3);
        r_type(7'h00, 3'b101, 5'd5, 5'd1, 5'd3);
        r_type(7'h20, 3'b101, 5'd6, 5'd1, 5'd3);
        i_type(3'b001, 5'd7, 5'd2, rand_bits(5));
        i_type(3'b101, 5'd8, 5'd1, rand_bits(5));
        i_type(3'b101, 5'd9, 5'd1, rand_bits(5) | 12'h400);
        r_type(7'h00, 3'b010, 5'd10, 5'd1, 5'd2);
        r_type(7'h00, 3'b011, 5'd11, 5'd1, 5'd2);
        r_type(7'h00, 3'b010, 5'd12, 5'd2, 5'd1);
        i_type(3'b010, 5'd13, 5'd1, rand_bits(12));
        i_type(3'b011, 5'd14, 5'd2, rand_bits(11) | 12'h800);
        i_type(3'b011, 5'd15, 5'd1, rand_bits(12));
        run_program("shift_compare");
    endtask

    task automatic load_store_test();
        i_type(3'b000, 5'd1, 5'd0, 12'h200);
        i_type(3'b000, 5'd2, 5'd0, rand_bits(12));
        i_type(3'b000, 5'd3, 5'd0, rand_bits(12));
        i_type(3'b000, 5'd4, 5'd0, rand_bits(12));
        store_word(5'd2, 5'd1, 12'd0);
        store_word(5'd3, 5'd1, 12'd4);
        store_word(5'd4, 5'd1, 12'd8);
        i_type(3'b000, 5'd5, 5'd1, 12'd16);
        load_word(5'd6, 5'd1, 12'd0);
        load_word(5'd7, 5'd1, 12'd4);
        load_word(5'd8, 5'd5, -12'sd8);
        load_word(5'd9, 5'd5, -12'sd12);
        run_program("load_store");
    endtask

    task automatic x0_illegal_test();
        i_type(3'b000, 5'd0, 5'd0, rand_bits(12));
        i_type(3'b000, 5'd1, 5'd0, rand_bits(12));
        r_type(7'h00, 3'b000, 5'd2, 5'd0, 5'd0);
        r_type(7'h00, 3'b000, 5'd3, 5'd1, 5'd0);
        // funct7 01 targeting x1, then an unknown opcode
        raw_word({7'h01, 5'd1, 5'd1, 3'b000, 5'd1, 7'h33});
        raw_word(32'hffff_ffff);
        r_type(7'h00, 3'b000, 5'd4, 5'd1, 5'd0);
        r_type(7'h00, 3'b000, 5'd5, 5'd2, 5'd3);
        run_program("x0_illegal");
    endtask

    initial begin
        rst       = 1'b1;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        foreach (model[i]) model[i] = '0;
        fill_memory();
        reset_test();
        arith_test();
        shift_compare_test();
        load_store_test();
        x0_illegal_test();
        $display("checks %0d, check errors %0d, timeouts %0d",
                 checks, check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== testbench/tb_clock.sv ====
module tb_clock #(
    parameter int period = 100
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always #(period / 2) clk = ~clk;

endmodule

// ==== verilog/cpu_top.sv ====
`include "core_defines.svh"

module cpu_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load_en,
    input  logic [$clog2(`CORE_MEM_WORDS)-1:0] load_addr,
    input  logic [`CORE_XLEN-1:0]             load_data,
    output logic                              retire,
    output core_pkg::retire_t                 retire_info
);

    logic [`CORE_XLEN-1:0] imem_addr;
    logic [`CORE_XLEN-1:0] imem_data;
    core_pkg::dmem_req_t   dmem_req;
    logic [`CORE_XLEN-1:0] dmem_rdata;

    core u_core (
        .clk         (clk),
        .rst         (rst),
        .imem_addr   (imem_addr),
        .imem_data   (imem_data),
        .dmem_req    (dmem_req),
        .dmem_rdata  (dmem_rdata),
        .retire      (retire),
        .retire_info (retire_info)
    );

    memory u_memory (
        .clk        (clk),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_req   (dmem_req),
        .dmem_rdata (dmem_rdata),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

endmodule

// ==== verilog/memory.sv ====
`include "core_defines.svh"

module memory #(
    parameter int words = `CORE_MEM_WORDS
) (
    input  logic                       clk,
    input  logic [`CORE_XLEN-1:0]      imem_addr,
    output logic [`CORE_XLEN-1:0]      imem_data,
    input  core_pkg::dmem_req_t        dmem_req,
    output logic [`CORE_XLEN-1:0]      dmem_rdata,
    input  logic                       load_en,
    input  logic [$clog2(words)-1:0]   load_addr,
    input  logic [`CORE_XLEN-1:0]      load_data
);

    localparam int aw = $clog2(words);

    logic [`CORE_XLEN-1:0] mem [words];
    logic [aw-1:0]         iaddr;
    logic [aw-1:0]         daddr;

    // word index from byte address
    assign iaddr = imem_addr[aw+1:2];
    assign daddr = dmem_req.addr[aw+1:2];

    always_ff @(posedge clk) begin
        imem_data <= mem[iaddr];
        if (dmem_req.read) begin
            dmem_rdata <= mem[daddr];
        end
    end

    // program load wins over a store
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (dmem_req.write) begin
            mem[daddr] <= dmem_req.wdata;
        end
    end

    a_no_load_store: assert property (@(posedge clk) !(load_en && dmem_req.write));

endmodule

// ==== verilog/core.sv ====
`include "core_defines.svh"

module core (
    input  logic                  clk,
    input  logic                  rst,
    output logic [`CORE_XLEN-1:0] imem_addr,
    input  logic [`CORE_XLEN-1:0] imem_data,
    output core_pkg::dmem_req_t   dmem_req,
    input  logic [`CORE_XLEN-1:0] dmem_rdata,
    output logic                  retire,
    output core_pkg::retire_t     retire_info
);

    core_pkg::stage_e      stage;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] inst_pc;
    rv_isa_pkg::inst_t     fetched;
    rv_isa_pkg::inst_t     ir;
    core_pkg::decoded_t    dec;
    logic [`CORE_XLEN-1:0] rs1_data;
    logic [`CORE_XLEN-1:0] rs2_data;
    logic [`CORE_XLEN-1:0] rs1_q;
    logic [`CORE_XLEN-1:0] rs2_q;
    logic [`CORE_XLEN-1:0] alu_b;
    logic [`CORE_XLEN-1:0] alu_result;
    logic [`CORE_XLEN-1:0] alu_q;
    logic [`CORE_XLEN-1:0] wb_value;
    logic                  rf_we;

    assign imem_addr = pc;
    assign fetched   = imem_data;

    decoder u_decoder (
        .inst (ir),
        .dec  (dec)
    );

    // operand reads use the word as it arrives from memory
    register_file u_register_file (
        .clk      (clk),
        .rst      (rst),
        .rs1_addr (fetched.r_fmt.rs1),
        .rs2_addr (fetched.r_fmt.rs2),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .we       (rf_we),
        .rd_addr  (dec.rd),
        .rd_data  (wb_value)
    );

    assign alu_b = dec.use_imm ? dec.imm : rs2_q;

    alu u_alu (
        .op     (dec.alu_op),
        .a      (rs1_q),
        .b      (alu_b),
        .result (alu_result)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            stage  <= core_pkg::STAGE_FETCH;
            pc     <= `CORE_RESET_PC;
            retire <= 1'b0;
        end else begin
            // high for the whole writeback cycle
            retire <= stage == core_pkg::STAGE_MEMORY;
            case (stage)
                core_pkg::STAGE_FETCH: begin
                    pc    <= pc + `CORE_XLEN'd4;
                    stage <= core_pkg::STAGE_DECODE;
                end
                core_pkg::STAGE_DECODE:  stage <= core_pkg::STAGE_EXECUTE;
                core_pkg::STAGE_EXECUTE: stage <= core_pkg::STAGE_MEMORY;
                core_pkg::STAGE_MEMORY:  stage <= core_pkg::STAGE_WRITEBACK;
                default:                 stage <= core_pkg::STAGE_FETCH;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (stage)
            core_pkg::STAGE_FETCH: inst_pc <= pc;
            core_pkg::STAGE_DECODE: begin
                ir    <= fetched;
                rs1_q <= rs1_data;
                rs2_q <= rs2_data;
            end
            // also the LW/SW byte address
            core_pkg::STAGE_EXECUTE: alu_q <= alu_result;
            default: ;
        endcase
    end

    assign dmem_req.read  = stage == core_pkg::STAGE_MEMORY && dec.mem_read;
    assign dmem_req.write = stage == core_pkg::STAGE_MEMORY && dec.mem_write;
    assign dmem_req.addr  = alu_q;
    assign dmem_req.wdata = rs2_q;

    assign wb_value = dec.mem_read ? dmem_rdata : alu_q;
    assign rf_we    = stage == core_pkg::STAGE_WRITEBACK && dec.reg_write;

    assign retire_info.pc        = inst_pc;
    assign retire_info.rd        = dec.rd;
    assign retire_info.value     = wb_value;
    assign retire_info.reg_write = dec.reg_write;

    a_one_strobe: assert property (@(posedge clk) disable iff (rst)
        !(dmem_req.read && dmem_req.write));

    a_retire_in_wb: assert property (@(posedge clk) disable iff (rst)
        retire |-> stage == core_pkg::STAGE_WRITEBACK);

endmodule

// ==== verilog/register_file.sv ====
`include "core_defines.svh"

module register_file (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [4:0]            rs1_addr,
    input  logic [4:0]            rs2_addr,
    output logic [`CORE_XLEN-1:0] rs1_data,
    output logic [`CORE_XLEN-1:0] rs2_data,
    input  logic                  we,
    input  logic [4:0]            rd_addr,
    input  logic [`CORE_XLEN-1:0] rd_data
);

    logic [`CORE_XLEN-1:0] regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd_addr != 5'd0) begin
            regs[rd_addr] <= rd_data;
        end
    end

    // x0 is hardwired
    assign rs1_data = (rs1_addr == 5'd0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == 5'd0) ? '0 : regs[rs2_addr];

endmodule

// ==== verilog/alu.sv ====
`include "core_defines.svh"

module alu (
    input  rv_isa_pkg::alu_op_e   op,
    input  logic [`CORE_XLEN-1:0] a,
    input  logic [`CORE_XLEN-1:0] b,
    output logic [`CORE_XLEN-1:0] result
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            rv_isa_pkg::ALU_ADD:  result = a + b;
            rv_isa_pkg::ALU_SUB:  result = a - b;
            rv_isa_pkg::ALU_AND:  result = a & b;
            rv_isa_pkg::ALU_OR:   result = a | b;
            rv_isa_pkg::ALU_XOR:  result = a ^ b;
            rv_isa_pkg::ALU_SLL:  result = a << shamt;
            rv_isa_pkg::ALU_SRL:  result = a >> shamt;
            // arithmetic shift keeps the sign
            rv_isa_pkg::ALU_SRA:  result = $signed(a) >>> shamt;
            rv_isa_pkg::ALU_SLT:  result = {{(`CORE_XLEN-1){1'b0}}, lt_signed};
            rv_isa_pkg::ALU_SLTU: result = {{(`CORE_XLEN-1){1'b0}}, lt_unsigned};
            default:              result = '0;
        endcase
    end

endmodule

// ==== verilog/decoder.sv ====
`include "core_defines.svh"

module decoder (
    input  rv_isa_pkg::inst_t  inst,
    output core_pkg::decoded_t dec
);

    logic                  f7_base;
    logic                  f7_alt;
    logic                  shift_f3;
    logic [`CORE_XLEN-1:0] imm_i;
    logic [`CORE_XLEN-1:0] imm_s;

    function automatic rv_isa_pkg::alu_op_e funct3_op(input logic [2:0] funct3, input logic alt);
        rv_isa_pkg::alu_op_e op;
        case (funct3)
            rv_isa_pkg::F3_ADD_SUB: op = alt ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
            rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
            rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
            rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
            rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
            rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
            rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
            default:                op = rv_isa_pkg::ALU_AND;
        endcase
        return op;
    endfunction

    assign f7_base  = inst.r_fmt.funct7 == rv_isa_pkg::F7_BASE;
    assign f7_alt   = inst.r_fmt.funct7 == rv_isa_pkg::F7_ALT;
    assign shift_f3 = inst.r_fmt.funct3 inside {rv_isa_pkg::F3_SLL, rv_isa_pkg::F3_SRL_SRA};

    assign imm_i = {{(`CORE_XLEN-12){inst.i_fmt.imm[11]}}, inst.i_fmt.imm};
    assign imm_s = {{(`CORE_XLEN-12){inst.s_fmt.imm_hi[6]}}, inst.s_fmt.imm_hi, inst.s_fmt.imm_lo};

    always_comb begin
        dec           = '0;
        dec.rs1       = inst.r_fmt.rs1;
        dec.rs2       = inst.r_fmt.rs2;
        dec.rd        = inst.r_fmt.rd;
        dec.imm       = imm_i;
        dec.alu_op    = rv_isa_pkg::ALU_ADD;
        case (inst.r_fmt.opcode)
            rv_isa_pkg::OPC_OP: begin
                dec.alu_op    = funct3_op(inst.r_fmt.funct3, f7_alt);
                dec.reg_write = 1'b1;
                dec.illegal   = !(f7_base || (f7_alt && inst.r_fmt.funct3 inside
                                  {rv_isa_pkg::F3_ADD_SUB, rv_isa_pkg::F3_SRL_SRA}));
            end
            rv_isa_pkg::OPC_OP_IMM: begin
                // upper imm bits act as funct7 only for shifts
                dec.alu_op    = funct3_op(inst.i_fmt.funct3,
                                          f7_alt && inst.i_fmt.funct3 == rv_isa_pkg::F3_SRL_SRA);
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.illegal   = shift_f3 && !(f7_base || (f7_alt &&
                                inst.i_fmt.funct3 == rv_isa_pkg::F3_SRL_SRA));
            end
            rv_isa_pkg::OPC_LOAD: begin
                dec.use_imm   = 1'b1;
                dec.reg_write = 1'b1;
                dec.mem_read  = 1'b1;
                dec.illegal   = inst.i_fmt.funct3 != rv_isa_pkg::F3_WORD;
            end
            rv_isa_pkg::OPC_STORE: begin
                dec.imm       = imm_s;
                dec.use_imm   = 1'b1;
                dec.mem_write = 1'b1;
                dec.illegal   = inst.s_fmt.funct3 != rv_isa_pkg::F3_WORD;
            end
            default: dec.illegal = 1'b1;
        endcase
        // illegal words retire as no-ops
        if (dec.illegal) begin
            dec.reg_write = 1'b0;
            dec.mem_read  = 1'b0;
            dec.mem_write = 1'b0;
        end
    end

endmodule

// ==== verilog/core_pkg.sv ====
`include "core_defines.svh"

package core_pkg;

    typedef enum logic [2:0] {
        STAGE_FETCH,
        STAGE_DECODE,
        STAGE_EXECUTE,
        STAGE_MEMORY,
        STAGE_WRITEBACK
    } stage_e;

    typedef struct packed {
        logic [4:0]            rs1;
        logic [4:0]            rs2;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] imm;
        rv_isa_pkg::alu_op_e   alu_op;
        logic                  use_imm;
        logic                  reg_write;
        logic                  mem_read;
        logic                  mem_write;
        logic                  illegal;
    } decoded_t;

    // addr is a byte address, low two bits unused
    typedef struct packed {
        logic                  read;
        logic                  write;
        logic [`CORE_XLEN-1:0] addr;
        logic [`CORE_XLEN-1:0] wdata;
    } dmem_req_t;

    typedef struct packed {
        logic [`CORE_XLEN-1:0] pc;
        logic [4:0]            rd;
        logic [`CORE_XLEN-1:0] value;
        logic                  reg_write;
    } retire_t;

endpackage

// ==== verilog/rv_isa_pkg.sv ====
package rv_isa_pkg;

    // major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LOAD   = 7'b0000011;
    localparam logic [6:0] OPC_STORE  = 7'b0100011;

    // funct3 for OP and OP_IMM
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // word width for LW and SW
    localparam logic [2:0] F3_WORD    = 3'b010;

    localparam logic [6:0] F7_BASE    = 7'b0000000;
    localparam logic [6:0] F7_ALT     = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // one instruction word seen through each encoding
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
        s_fmt_t s_fmt;
    } inst_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU
    } alu_op_e;

endpackage

// ==== verilog/core_defines.svh ====
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// memory size in 32-bit words
`define CORE_MEM_WORDS 256

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

// integer register and data width
`define CORE_XLEN 32

`endif
